// ==== verilog/v33_params.svh ====
`ifndef V33_PARAMS_SVH
`define V33_PARAMS_SVH

// Datapath and register word width
`define V33_WORD_W     16

// Data port address width
`define V33_ADDR_W     16

// AW, CW, DW, BW, SP, BP, IX, IY
`define V33_REG_COUNT  8

// Program counter after reset
`define V33_RESET_PC   16'h0000

// Width of an immediate I/O port number
`define V33_IO_ADDR_W  8

`endif

// ==== verilog/v33_pkg.sv ====
`include "v33_params.svh"

package v33_pkg;

    // Instruction class
    typedef enum logic [2:0] {
        NOP,
        MOV,
        ALU,
        B_COND,
        OUT
    } opcode_e;

    typedef enum logic [2:0] {
        ACC,
        IMM,
        IMM_EXT,    // Sign-extended 8-bit immediate
        MODRM,
        REG
    } operand_e;

    typedef enum logic {
        BYTE,
        WORD
    } width_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR
    } alu_op_e;

    typedef enum logic [2:0] {AW, CW, DW, BW, SP, BP, IX, IY} reg16_index_e;
    typedef enum logic [2:0] {AL, CL, DL, BL, AH, CH, DH, BH} reg8_index_e;

    typedef struct packed {
        logic v;
        logic s;
        logic z;
        logic cy;
        logic p;
    } flags_t;

    // One general register seen as a word or as two bytes
    typedef union packed {
        logic [`V33_WORD_W-1:0] word;
        struct packed {
            logic [`V33_WORD_W/2-1:0] hi;
            logic [`V33_WORD_W/2-1:0] lo;
        } bytes;
    } gpr_word_u;

endpackage

// ==== verilog/v33_ifs.sv ====
`timescale 1ns/1ps
`include "v33_params.svh"

interface reg_port_if;
    logic [2:0]             rd0_idx;
    logic [2:0]             rd1_idx;
    v33_pkg::width_e        rd_width;
    logic [`V33_WORD_W-1:0] rd0_data;
    logic [`V33_WORD_W-1:0] rd1_data;

    logic                   wr_en;
    logic [2:0]             wr_idx;
    v33_pkg::width_e        wr_width;
    logic [`V33_WORD_W-1:0] wr_data;

    // Address registers for the EA adder
    logic [`V33_WORD_W-1:0] base_bw, base_bp, base_ix, base_iy;

    modport ctrl (output rd0_idx, rd1_idx, rd_width, wr_en, wr_idx, wr_width, wr_data,
                  input rd0_data, rd1_data);
    modport regs (input rd0_idx, rd1_idx, rd_width, wr_en, wr_idx, wr_width, wr_data,
                  output rd0_data, rd1_data, base_bw, base_bp, base_ix, base_iy);
    modport agen (input base_bw, base_bp, base_ix, base_iy);
endinterface

interface alu_if;
    logic                   start;
    v33_pkg::alu_op_e       op;
    logic [`V33_WORD_W-1:0] a;
    logic [`V33_WORD_W-1:0] b;
    v33_pkg::width_e        width;
    logic                   flags_write;
    logic [3:0]             cond;
    logic [`V33_WORD_W-1:0] result;
    logic                   cond_true;

    modport ctrl (output start, op, a, b, width, flags_write, cond, input result, cond_true);
    modport alu (input start, op, a, b, width, flags_write, cond, output result, cond_true);
endinterface

// ==== verilog/exec_control.sv ====
`timescale 1ns/1ps
`include "v33_params.svh"

module exec_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    op_valid,
    output logic                    op_ready,
    input  v33_pkg::opcode_e        op_code,
    input  v33_pkg::width_e         op_width,
    input  v33_pkg::operand_e       op_src0,
    input  v33_pkg::operand_e       op_src1,
    input  v33_pkg::operand_e       op_dest,
    input  logic [1:0]              op_mod,
    input  logic [2:0]              op_rm,
    input  logic [2:0]              op_reg,
    input  v33_pkg::alu_op_e        op_alu,
    input  logic [3:0]              op_cond,
    input  logic [3:0]              op_size,
    input  logic [`V33_WORD_W-1:0]  op_imm,
    input  logic [`V33_ADDR_W-1:0]  ea,
    output logic [`V33_WORD_W-1:0]  pc,
    output logic                    pc_load,
    output logic                    mem_req,
    output logic                    mem_write,
    output logic                    mem_io,
    output logic                    mem_wide,
    output logic [`V33_ADDR_W-1:0]  mem_addr,
    output logic [`V33_WORD_W-1:0]  mem_wdata,
    input  logic [`V33_WORD_W-1:0]  mem_rdata,
    input  logic                    mem_done,
    reg_port_if.ctrl                reg_port,
    alu_if.ctrl                     alu_port
);

localparam int W = `V33_WORD_W;
localparam int A = `V33_ADDR_W;
localparam int IO_W = `V33_IO_ADDR_W;

typedef enum logic [2:0] {IDLE, READ_MEM, EXECUTE, ALU_WAIT, STORE, WRITE_MEM} state_e;

state_e state;

v33_pkg::opcode_e  code_q;
v33_pkg::width_e   width_q;
v33_pkg::operand_e src0_q, src1_q, dest_q;
v33_pkg::alu_op_e  alu_q;
logic [1:0]        mod_q;
logic [2:0]        rm_q, reg_q;
logic [3:0]        cond_q;
logic [W-1:0]      imm_q, mem_data, result_q;
logic [A-1:0]      ea_q;
logic [W-1:0]      src0_val, src1_val;
logic              mem_wait;    // Request sent, mem_done not yet seen
logic              mem_operand;
logic              dest_is_mem;

function automatic logic [2:0] operand_idx(v33_pkg::operand_e sel, logic [2:0] rm,
                                           logic [2:0] rg);
    case (sel)
        v33_pkg::MODRM: return rm;
        v33_pkg::REG:   return rg;
        default:        return v33_pkg::AW;   // AW and AL share index 0
    endcase
endfunction

function automatic logic [W-1:0] operand_val(v33_pkg::operand_e sel, logic [W-1:0] rdata);
    logic [W-1:0] val;
    case (sel)
        v33_pkg::IMM:     val = imm_q;
        v33_pkg::IMM_EXT: val = {{(W-8){imm_q[7]}}, imm_q[7:0]};
        v33_pkg::MODRM:   val = (mod_q == 2'b11) ? rdata : mem_data;
        default:          val = rdata;
    endcase
    if (width_q == v33_pkg::BYTE)
        val[W-1:8] = '0;
    return val;
endfunction

assign op_ready = (state == IDLE);
assign mem_operand = (op_code == v33_pkg::MOV || op_code == v33_pkg::ALU) && op_mod != 2'b11
                     && (op_src0 == v33_pkg::MODRM || op_src1 == v33_pkg::MODRM);
assign dest_is_mem = (dest_q == v33_pkg::MODRM) && (mod_q != 2'b11);

// OUT reads AW and DW as words
assign reg_port.rd0_idx  = (code_q == v33_pkg::OUT) ? v33_pkg::AW
                                                     : operand_idx(src0_q, rm_q, reg_q);
assign reg_port.rd1_idx  = (code_q == v33_pkg::OUT) ? v33_pkg::DW
                                                     : operand_idx(src1_q, rm_q, reg_q);
assign reg_port.rd_width = (code_q == v33_pkg::OUT) ? v33_pkg::WORD : width_q;

assign reg_port.wr_en    = (state == STORE) && !dest_is_mem && dest_q != v33_pkg::IMM
                           && dest_q != v33_pkg::IMM_EXT;
assign reg_port.wr_idx   = operand_idx(dest_q, rm_q, reg_q);
assign reg_port.wr_width = width_q;
assign reg_port.wr_data  = result_q;

always_comb begin
    src0_val = operand_val(src0_q, reg_port.rd0_data);
    src1_val = operand_val(src1_q, reg_port.rd1_data);
end

assign alu_port.start       = (state == EXECUTE) && (code_q == v33_pkg::ALU);
assign alu_port.op          = alu_q;
assign alu_port.a           = src0_val;
assign alu_port.b           = src1_val;
assign alu_port.width       = width_q;
assign alu_port.flags_write = (state == ALU_WAIT);
assign alu_port.cond        = cond_q;

always_ff @(posedge clk) begin
    pc_load <= 1'b0;
    mem_req <= 1'b0;
    if (reset) begin
        state    <= IDLE;
        pc       <= `V33_RESET_PC;
        mem_wait <= 1'b0;
    end else begin
        mem_wait <= (mem_wait | mem_req) & ~mem_done;
        case (state)
            IDLE: if (op_valid) begin
                code_q  <= op_code;
                width_q <= op_width;
                src0_q  <= op_src0;
                src1_q  <= op_src1;
                dest_q  <= op_dest;
                mod_q   <= op_mod;
                rm_q    <= op_rm;
                reg_q   <= op_reg;
                alu_q   <= op_alu;
                cond_q  <= op_cond;
                imm_q   <= op_imm;
                ea_q    <= ea;
                pc      <= pc + W'(op_size);
                if (mem_operand) begin
                    mem_req   <= 1'b1;
                    mem_addr  <= ea;
                    mem_write <= 1'b0;
                    mem_io    <= 1'b0;
                    mem_wide  <= (op_width == v33_pkg::WORD);
                    state     <= READ_MEM;
                end else begin
                    state <= EXECUTE;
                end
            end
            READ_MEM: if (mem_done) begin
                mem_data <= mem_rdata;
                state    <= EXECUTE;
            end
            EXECUTE: begin
                case (code_q)
                    v33_pkg::MOV: begin
                        result_q <= src0_val;
                        state    <= STORE;
                    end
                    v33_pkg::ALU: state <= ALU_WAIT;
                    v33_pkg::B_COND: begin
                        if (alu_port.cond_true) begin
                            pc      <= pc + {{(W-8){imm_q[7]}}, imm_q[7:0]};
                            pc_load <= 1'b1;
                        end
                        state <= IDLE;
                    end
                    v33_pkg::OUT: begin
                        mem_req   <= 1'b1;
                        mem_write <= 1'b1;
                        mem_io    <= 1'b1;
                        mem_wide  <= (width_q == v33_pkg::WORD);
                        mem_addr  <= (src0_q == v33_pkg::IMM) ? A'(imm_q[IO_W-1:0])
                                                              : reg_port.rd1_data;
                        mem_wdata <= (width_q == v33_pkg::WORD) ? reg_port.rd0_data
                                                                : {8'd0, reg_port.rd0_data[7:0]};
                        state     <= WRITE_MEM;
                    end
                    default: state <= IDLE;
                endcase
            end
            ALU_WAIT: begin
                result_q <= alu_port.result;
                state    <= STORE;
            end
            STORE: begin
                if (dest_is_mem) begin
                    mem_req   <= 1'b1;
                    mem_write <= 1'b1;
                    mem_io    <= 1'b0;
                    mem_wide  <= (width_q == v33_pkg::WORD);
                    mem_addr  <= ea_q;
                    mem_wdata <= result_q;
                    state     <= WRITE_MEM;
                end else begin
                    state <= IDLE;
                end
            end
            WRITE_MEM: if (mem_done) state <= IDLE;
            default: state <= IDLE;
        endcase
    end
end

// One outstanding data transfer at a time
assert property (@(posedge clk) disable iff (reset) mem_wait |-> !mem_req);
assert property (@(posedge clk) disable iff (reset) (mem_req || mem_wait) |-> !op_ready);

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps
`include "v33_params.svh"

module register_file (
    input  logic        clk,
    input  logic        reset,
    reg_port_if.regs    reg_port
);

localparam int W = `V33_WORD_W;

v33_pkg::gpr_word_u gpr [`V33_REG_COUNT];

// Byte indices 4..7 are the high halves of AW..BW
function automatic logic [2:0] reg_sel(logic [2:0] idx, v33_pkg::width_e width);
    return (width == v33_pkg::BYTE) ? {1'b0, idx[1:0]} : idx;
endfunction

function automatic logic [W-1:0] reg_view(v33_pkg::gpr_word_u r, logic [2:0] idx,
                                          v33_pkg::width_e width);
    if (width == v33_pkg::WORD)
        return r.word;
    if (idx[2])
        return {8'd0, r.bytes.hi};
    return {8'd0, r.bytes.lo};
endfunction

assign reg_port.rd0_data = reg_view(gpr[reg_sel(reg_port.rd0_idx, reg_port.rd_width)],
                                    reg_port.rd0_idx, reg_port.rd_width);
assign reg_port.rd1_data = reg_view(gpr[reg_sel(reg_port.rd1_idx, reg_port.rd_width)],
                                    reg_port.rd1_idx, reg_port.rd_width);

assign reg_port.base_bw = gpr[v33_pkg::BW].word;
assign reg_port.base_bp = gpr[v33_pkg::BP].word;
assign reg_port.base_ix = gpr[v33_pkg::IX].word;
assign reg_port.base_iy = gpr[v33_pkg::IY].word;

always_ff @(posedge clk) begin
    if (reset) begin
        for (int i = 0; i < `V33_REG_COUNT; i++)
            gpr[i] <= '0;
    end else if (reg_port.wr_en) begin
        if (reg_port.wr_width == v33_pkg::WORD)
            gpr[reg_port.wr_idx].word <= reg_port.wr_data;
        else if (reg_port.wr_idx[2])
            gpr[{1'b0, reg_port.wr_idx[1:0]}].bytes.hi <= reg_port.wr_data[7:0];
        else
            gpr[{1'b0, reg_port.wr_idx[1:0]}].bytes.lo <= reg_port.wr_data[7:0];
    end
end

assert property (@(posedge clk) disable iff (reset)
    reg_port.wr_en |-> !$isunknown(reg_port.wr_idx));

endmodule

// ==== verilog/address_gen.sv ====
`timescale 1ns/1ps
`include "v33_params.svh"

module address_gen (
    reg_port_if.agen                reg_port,
    input  logic [1:0]              mod,
    input  logic [2:0]              rm,
    input  logic [`V33_WORD_W-1:0]  disp,
    output logic [`V33_ADDR_W-1:0]  ea
);

logic [`V33_ADDR_W-1:0] base;

always_comb begin
    case (rm)
        3'd0: base = reg_port.base_bw + reg_port.base_ix;
        3'd1: base = reg_port.base_bw + reg_port.base_iy;
        3'd2: base = reg_port.base_bp + reg_port.base_ix;
        3'd3: base = reg_port.base_bp + reg_port.base_iy;
        3'd4: base = reg_port.base_ix;
        3'd5: base = reg_port.base_iy;
        3'd6: base = (mod == 2'b00) ? disp : reg_port.base_bp;   // Direct address
        default: base = reg_port.base_bw;
    endcase

    case (mod)
        2'b01: ea = base + {8'd0, disp[7:0]};
        2'b10: ea = base + disp;
        default: ea = base;
    endcase
end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`include "v33_params.svh"

module alu (
    input  logic    clk,
    input  logic    reset,
    alu_if.alu      alu_port
);

localparam int W = `V33_WORD_W;

logic [W:0]      sum_w;
logic [8:0]      sum_b;     // Byte sum for the byte carry
logic [W-1:0]    res;
logic            wide, arith, a_msb, b_msb, r_msb, cond_base;
v33_pkg::flags_t flags_next, flags_q, psw;

always_comb begin
    case (alu_port.op)
        v33_pkg::ADD: sum_w = {1'b0, alu_port.a} + {1'b0, alu_port.b};
        v33_pkg::SUB: sum_w = {1'b0, alu_port.a} - {1'b0, alu_port.b};
        v33_pkg::AND: sum_w = {1'b0, alu_port.a & alu_port.b};
        v33_pkg::OR:  sum_w = {1'b0, alu_port.a | alu_port.b};
        v33_pkg::XOR: sum_w = {1'b0, alu_port.a ^ alu_port.b};
        default:      sum_w = '0;
    endcase
    sum_b = (alu_port.op == v33_pkg::SUB) ? {1'b0, alu_port.a[7:0]} - {1'b0, alu_port.b[7:0]}
                                          : {1'b0, alu_port.a[7:0]} + {1'b0, alu_port.b[7:0]};

    wide  = (alu_port.width == v33_pkg::WORD);
    arith = (alu_port.op == v33_pkg::ADD) || (alu_port.op == v33_pkg::SUB);
    res   = wide ? sum_w[W-1:0] : {8'd0, sum_w[7:0]};
    a_msb = wide ? alu_port.a[W-1] : alu_port.a[7];
    b_msb = wide ? alu_port.b[W-1] : alu_port.b[7];
    r_msb = wide ? res[W-1] : res[7];

    flags_next.cy = arith & (wide ? sum_w[W] : sum_b[8]);   // Borrow on SUB
    flags_next.v  = arith & (r_msb != a_msb)
                    & ((alu_port.op == v33_pkg::SUB) ? (a_msb != b_msb) : (a_msb == b_msb));
    flags_next.s  = r_msb;
    flags_next.z  = (res == '0);
    flags_next.p  = ~^res[7:0];
end

always_ff @(posedge clk) begin
    if (alu_port.start) begin
        alu_port.result <= res;
        flags_q         <= flags_next;
    end
end

always_ff @(posedge clk) begin
    if (reset)
        psw <= '0;
    else if (alu_port.flags_write)
        psw <= flags_q;
end

// Odd condition codes negate the even one below
always_comb begin
    case (alu_port.cond[3:1])
        3'd0: cond_base = psw.v;
        3'd1: cond_base = psw.cy;
        3'd2: cond_base = psw.z;
        3'd3: cond_base = psw.cy | psw.z;
        3'd4: cond_base = psw.s;
        3'd5: cond_base = psw.p;
        3'd6: cond_base = psw.s ^ psw.v;
        default: cond_base = (psw.s ^ psw.v) | psw.z;
    endcase
end

assign alu_port.cond_true = cond_base ^ alu_port.cond[0];

assert property (@(posedge clk) disable iff (reset) alu_port.start |=> !alu_port.start);

endmodule

// ==== verilog/v33_exec.sv ====
`timescale 1ns/1ps
`include "v33_params.svh"

module v33_exec (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    op_valid,
    output logic                    op_ready,
    input  v33_pkg::opcode_e        op_code,
    input  v33_pkg::width_e         op_width,
    input  v33_pkg::operand_e       op_src0,
    input  v33_pkg::operand_e       op_src1,
    input  v33_pkg::operand_e       op_dest,
    input  logic [1:0]              op_mod,
    input  logic [2:0]              op_rm,
    input  logic [2:0]              op_reg,
    input  v33_pkg::alu_op_e        op_alu,
    input  logic [3:0]              op_cond,
    input  logic [3:0]              op_size,
    input  logic [`V33_WORD_W-1:0]  op_imm,
    input  logic [`V33_WORD_W-1:0]  op_disp,

    output logic [`V33_WORD_W-1:0]  pc,
    output logic                    pc_load,

    output logic                    mem_req,
    output logic                    mem_write,
    output logic                    mem_io,
    output logic                    mem_wide,
    output logic [`V33_ADDR_W-1:0]  mem_addr,
    output logic [`V33_WORD_W-1:0]  mem_wdata,
    input  logic [`V33_WORD_W-1:0]  mem_rdata,
    input  logic                    mem_done
);

logic [`V33_ADDR_W-1:0] ea;    // EA of the instruction being offered

reg_port_if reg_bus ();
alu_if      alu_bus ();

exec_control exec_control_inst (
    .clk, .reset,
    .op_valid, .op_ready, .op_code, .op_width,
    .op_src0, .op_src1, .op_dest,
    .op_mod, .op_rm, .op_reg, .op_alu, .op_cond, .op_size, .op_imm,
    .ea,
    .pc, .pc_load,
    .mem_req, .mem_write, .mem_io, .mem_wide,
    .mem_addr, .mem_wdata, .mem_rdata, .mem_done,
    .reg_port(reg_bus),
    .alu_port(alu_bus)
);

register_file register_file_inst (
    .clk, .reset,
    .reg_port(reg_bus)
);

address_gen address_gen_inst (
    .reg_port(reg_bus),
    .mod(op_mod),
    .rm(op_rm),
    .disp(op_disp),
    .ea
);

alu alu_inst (
    .clk, .reset,
    .alu_port(alu_bus)
);

endmodule

// ==== tests/tb_v33_exec.sv ====
`timescale 1ns/1ps
`include "v33_params.svh"

module tb_v33_exec;

typedef logic [`V33_WORD_W-1:0] word_t;

localparam int WAIT_LIMIT = 200;
localparam int K_NONE     = 0;
localparam int K_READ     = 1;
localparam int K_WRITE    = 2;
localparam int K_OUT      = 3;
localparam int K_IO_READ  = 4;

typedef struct {
    string             name;
    v33_pkg::opcode_e  code;
    v33_pkg::width_e   width;
    v33_pkg::operand_e src0, src1, dest;
    logic [1:0]        mod;
    logic [2:0]        rm, rg;
    v33_pkg::alu_op_e  alu;
    logic [3:0]        cond, size;
    word_t             imm, disp, rdata;
    word_t             exp_pc;
    logic              exp_load;
    int                exp_kind;
    word_t             exp_addr, exp_data;    // Memory address or I/O port
} row_t;

logic clk = 1'b0;
logic reset, op_valid, op_ready, pc_load;
v33_pkg::opcode_e  op_code;
v33_pkg::width_e   op_width;
v33_pkg::operand_e op_src0, op_src1, op_dest;
logic [1:0]        op_mod;
logic [2:0]        op_rm, op_reg;
v33_pkg::alu_op_e  op_alu;
logic [3:0]        op_cond, op_size;
word_t             op_imm, op_disp, pc, mem_addr, mem_wdata;
word_t             mem_rdata = '0;
logic              mem_req, mem_write, mem_io, mem_wide;
logic              mem_done = 1'b0;

row_t            rows[$];
row_t            row;
word_t           ref_regs [`V33_REG_COUNT];
v33_pkg::flags_t ref_flags;
word_t           ref_pc;
logic [31:0]     lfsr = 32'd77858;
int              errors = 0;
int              timeouts = 0;
int              checks = 0;
int              mem_delay = 0;
word_t           cur_rdata;
int              seen_count, seen_kind;
word_t           seen_addr, seen_data;
logic            seen_wide;

v33_exec v33_exec_inst (.*);

always #5 clk = ~clk;

function automatic word_t lfsr_take(int n);
    word_t val;
    logic b;
    val = '0;
    for (int i = 0; i < n; i++) begin
        b = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        val = {val[14:0], b};
    end
    return val;
endfunction

function automatic word_t ref_read(logic [2:0] idx, v33_pkg::width_e w);
    if (w == v33_pkg::WORD)
        return ref_regs[idx];
    if (idx[2])
        return {8'd0, ref_regs[{1'b0, idx[1:0]}][15:8]};    // AH..BH
    return {8'd0, ref_regs[idx][7:0]};
endfunction

task automatic ref_write(logic [2:0] idx, v33_pkg::width_e w, word_t d);
    if (w == v33_pkg::WORD)
        ref_regs[idx] = d;
    else if (idx[2])
        ref_regs[{1'b0, idx[1:0]}][15:8] = d[7:0];
    else
        ref_regs[idx][7:0] = d[7:0];
endtask

function automatic word_t ea_ref(logic [1:0] mod, logic [2:0] rm, word_t disp);
    word_t bw = ref_regs[v33_pkg::BW];
    word_t bp = ref_regs[v33_pkg::BP];
    word_t ix = ref_regs[v33_pkg::IX];
    word_t iy = ref_regs[v33_pkg::IY];
    word_t bases [8] = '{bw + ix, bw + iy, bp + ix, bp + iy, ix, iy, bp, bw};
    if (mod == 2'd0 && rm == 3'd6)
        return disp;
    if (mod == 2'd1)
        return bases[rm] + {8'd0, disp[7:0]};
    if (mod == 2'd2)
        return bases[rm] + disp;
    return bases[rm];
endfunction

// Arithmetic at operand width with flags from the unsigned and signed ranges
task automatic alu_ref(input v33_pkg::alu_op_e op, input v33_pkg::width_e w,
                       input word_t a, input word_t b, output word_t res);
    int span, ua, ub, sa, sb, full, sfull;
    logic arith;
    word_t mask;
    span = (w == v33_pkg::WORD) ? 65536 : 256;
    mask = 16'(span - 1);
    ua = int'(a & mask);
    ub = int'(b & mask);
    sa = (ua >= span / 2) ? ua - span : ua;
    sb = (ub >= span / 2) ? ub - span : ub;
    sfull = 0;
    arith = (op == v33_pkg::ADD) || (op == v33_pkg::SUB);
    case (op)
        v33_pkg::ADD: begin
            full = ua + ub;
            sfull = sa + sb;
        end
        v33_pkg::SUB: begin
            full = ua - ub;
            sfull = sa - sb;
        end
        v33_pkg::AND: full = ua & ub;
        v33_pkg::OR:  full = ua | ub;
        default:      full = ua ^ ub;
    endcase
    res = 16'(full) & mask;
    ref_flags.cy = arith && (full < 0 || full >= span);
    ref_flags.v  = arith && (sfull < -(span / 2) || sfull >= span / 2);
    ref_flags.z  = (res == '0);
    ref_flags.s  = (w == v33_pkg::WORD) ? res[15] : res[7];
    ref_flags.p  = ~^res[7:0];
endtask

function automatic logic cond_ref(v33_pkg::flags_t f, logic [3:0] c);
    logic t;
    case (c[3:1])
        3'd0: t = f.v;
        3'd1: t = f.cy;
        3'd2: t = f.z;
        3'd3: t = f.cy | f.z;
        3'd4: t = f.s;
        3'd5: t = f.p;
        3'd6: t = f.s ^ f.v;
        default: t = (f.s ^ f.v) | f.z;
    endcase
    return c[0] ? !t : t;    // Odd codes negate
endfunction

task automatic start_row(string name, v33_pkg::opcode_e code, v33_pkg::width_e w);
    row.name = name;
    row.code = code;
    row.width = w;
    row.src0 = v33_pkg::ACC;
    row.src1 = v33_pkg::ACC;
    row.dest = v33_pkg::ACC;
    row.mod = 2'd3;
    row.rm = 3'd0;
    row.rg = 3'd0;
    row.alu = v33_pkg::ADD;
    row.cond = 4'd0;
    row.size = 4'd2 + 4'(lfsr_take(2));
    row.imm = '0;
    row.disp = '0;
    row.rdata = '0;
    row.exp_load = 1'b0;
    row.exp_kind = K_NONE;
    row.exp_addr = '0;
    row.exp_data = '0;
    ref_pc = ref_pc + {12'd0, row.size};
endtask

task automatic push_row();
    row.exp_pc = ref_pc;
    rows.push_back(row);
endtask

task automatic mov_imm(string name, v33_pkg::width_e w, logic [2:0] idx, word_t val);
    start_row(name, v33_pkg::MOV, w);
    row.src0 = v33_pkg::IMM;
    row.dest = v33_pkg::REG;
    row.rg = idx;
    row.imm = val;
    ref_write(idx, w, val);
    push_row();
endtask

task automatic out_port(string name, v33_pkg::width_e w, logic use_dw, word_t port);
    start_row(name, v33_pkg::OUT, w);
    row.src0 = use_dw ? v33_pkg::ACC : v33_pkg::IMM;
    row.imm = port;
    row.exp_kind = K_OUT;
    row.exp_addr = use_dw ? ref_regs[v33_pkg::DW] : {8'd0, port[7:0]};
    row.exp_data = ref_read(3'd0, w);
    push_row();
endtask

// AW or AL op= CW/CL (register form) or an immediate
task automatic alu_row(string name, v33_pkg::alu_op_e op, v33_pkg::width_e w,
                       logic use_reg, word_t imm);
    word_t res;
    start_row(name, v33_pkg::ALU, w);
    row.alu = op;
    row.src0 = v33_pkg::REG;
    row.dest = v33_pkg::REG;
    row.src1 = use_reg ? v33_pkg::MODRM : v33_pkg::IMM;
    row.rm = 3'd1;
    row.imm = imm;
    alu_ref(op, w, ref_read(3'd0, w), use_reg ? ref_read(3'd1, w) : imm, res);
    ref_write(3'd0, w, res);
    push_row();
endtask

task automatic mem_read(string name, logic [1:0] mod, logic [2:0] rm, word_t disp,
                        word_t rdata);
    start_row(name, v33_pkg::MOV, v33_pkg::WORD);
    row.src0 = v33_pkg::MODRM;
    row.mod = mod;
    row.rm = rm;
    row.disp = disp;
    row.rdata = rdata;
    row.exp_kind = K_READ;
    row.exp_addr = ea_ref(mod, rm, disp);
    ref_regs[v33_pkg::AW] = rdata;
    push_row();
endtask

task automatic store_row(string name, logic [1:0] mod, logic [2:0] rm, word_t disp);
    start_row(name, v33_pkg::MOV, v33_pkg::WORD);
    row.dest = v33_pkg::MODRM;
    row.mod = mod;
    row.rm = rm;
    row.disp = disp;
    row.exp_kind = K_WRITE;
    row.exp_addr = ea_ref(mod, rm, disp);
    row.exp_data = ref_regs[v33_pkg::AW];
    push_row();
endtask

task automatic branch_row(string name, logic [3:0] cond, word_t d8);
    start_row(name, v33_pkg::B_COND, v33_pkg::WORD);
    row.cond = cond;
    row.imm = d8;
    row.exp_load = cond_ref(ref_flags, cond);
    if (row.exp_load)
        ref_pc = ref_pc + {{8{d8[7]}}, d8[7:0]};
    push_row();
endtask

task automatic build_table();
    word_t v;
    v33_pkg::alu_op_e op;
    ref_pc = `V33_RESET_PC;
    ref_flags = '0;
    foreach (ref_regs[i])
        ref_regs[i] = '0;

    mov_imm("mov_aw_word", v33_pkg::WORD, v33_pkg::AW, lfsr_take(16));
    mov_imm("mov_ah_byte", v33_pkg::BYTE, v33_pkg::AH, lfsr_take(16));
    out_port("out_after_mov", v33_pkg::WORD, 1'b0, lfsr_take(16));

    for (int i = 0; i < 10; i++) begin
        op = v33_pkg::alu_op_e'(i % 5);
        mov_imm("alu_setup_aw", v33_pkg::WORD, v33_pkg::AW, lfsr_take(16));
        mov_imm("alu_setup_cw", v33_pkg::WORD, v33_pkg::CW, lfsr_take(16));
        alu_row($sformatf("alu_imm_%s", op.name()), op, (i < 5) ? v33_pkg::WORD : v33_pkg::BYTE,
                1'b0, lfsr_take(16));
        out_port("alu_imm_out", (i < 5) ? v33_pkg::WORD : v33_pkg::BYTE, 1'b0, lfsr_take(16));
        alu_row($sformatf("alu_reg_%s", op.name()), op, (i < 5) ? v33_pkg::BYTE : v33_pkg::WORD,
                1'b1, '0);
        out_port("alu_reg_out", (i < 5) ? v33_pkg::BYTE : v33_pkg::WORD, 1'b0, lfsr_take(16));
    end

    mov_imm("set_bw", v33_pkg::WORD, v33_pkg::BW, lfsr_take(16));
    mov_imm("set_bp", v33_pkg::WORD, v33_pkg::BP, lfsr_take(16));
    mov_imm("set_ix", v33_pkg::WORD, v33_pkg::IX, lfsr_take(16));
    mov_imm("set_iy", v33_pkg::WORD, v33_pkg::IY, lfsr_take(16));
    for (int m = 0; m < 3; m++)
        for (int rm = 0; rm < 8; rm++) begin
            mem_read($sformatf("mem_read_mod%0d_rm%0d", m, rm), 2'(m), 3'(rm),
                     lfsr_take(16), lfsr_take(16));
            out_port("mem_read_out", v33_pkg::WORD, 1'b0, lfsr_take(16));
        end
    for (int rm = 0; rm < 8; rm++) begin
        mov_imm("store_setup_aw", v33_pkg::WORD, v33_pkg::AW, lfsr_take(16));
        store_row($sformatf("mem_write_mod%0d_rm%0d", rm % 3, rm), 2'(rm % 3), 3'(rm),
                  lfsr_take(16));
    end

    // Second pass uses equal operands so Z is set
    for (int c = 0; c < 32; c++) begin
        v = lfsr_take(16);
        mov_imm("branch_setup_aw", v33_pkg::WORD, v33_pkg::AW, v);
        if (c < 16)
            v = lfsr_take(16);
        mov_imm("branch_setup_cw", v33_pkg::WORD, v33_pkg::CW, v);
        op = (c < 16) ? v33_pkg::alu_op_e'(c % 5) : v33_pkg::SUB;
        alu_row($sformatf("branch_flags_%0d", c), op,
                (c % 2 == 1) ? v33_pkg::BYTE : v33_pkg::WORD, 1'b1, '0);
        branch_row($sformatf("branch_cond_%0d", c % 16), 4'(c % 16), lfsr_take(8));
    end

    mov_imm("set_dw", v33_pkg::WORD, v33_pkg::DW, lfsr_take(16));
    mov_imm("set_aw", v33_pkg::WORD, v33_pkg::AW, lfsr_take(16));
    out_port("out_dw_word", v33_pkg::WORD, 1'b1, '0);
    out_port("out_dw_byte", v33_pkg::BYTE, 1'b1, '0);
endtask

task automatic finish_run();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
        $display("Result: PASSED");
    else
        $display("Result: FAILED");
    $finish;
endtask

task automatic check_row(row_t r, int loads);
    checks++;
    if (pc !== r.exp_pc) begin
        errors++;
        $display("Error %s: pc expected %h, actual %h", r.name, r.exp_pc, pc);
    end
    if (loads != int'(r.exp_load)) begin
        errors++;
        $display("Error %s: pc_load pulses expected %0d, actual %0d", r.name, r.exp_load, loads);
    end
    if (seen_count != ((r.exp_kind == K_NONE) ? 0 : 1)) begin
        errors++;
        $display("Error %s: transfers expected %0d, actual %0d", r.name,
                 (r.exp_kind == K_NONE) ? 0 : 1, seen_count);
    end else if (r.exp_kind != K_NONE) begin
        if (seen_kind != r.exp_kind) begin
            errors++;
            $display("Error %s: transfer kind expected %0d, actual %0d", r.name, r.exp_kind,
                     seen_kind);
        end
        if (seen_addr !== r.exp_addr) begin
            errors++;
            $display("Error %s: address expected %h, actual %h", r.name, r.exp_addr, seen_addr);
        end
        if (seen_wide !== (r.width == v33_pkg::WORD)) begin
            errors++;
            $display("Error %s: mem_wide expected %b, actual %b", r.name,
                     r.width == v33_pkg::WORD, seen_wide);
        end
        if (r.exp_kind != K_READ && seen_data !== r.exp_data) begin
            errors++;
            $display("Error %s: data expected %h, actual %h", r.name, r.exp_data, seen_data);
        end
    end
endtask

task automatic run_row(row_t r);
    int n;
    int loads;
    seen_count = 0;
    seen_kind = K_NONE;
    cur_rdata = r.rdata;
    op_valid = 1'b1;
    op_code = r.code;
    op_width = r.width;
    op_src0 = r.src0;
    op_src1 = r.src1;
    op_dest = r.dest;
    op_mod = r.mod;
    op_rm = r.rm;
    op_reg = r.rg;
    op_alu = r.alu;
    op_cond = r.cond;
    op_size = r.size;
    op_imm = r.imm;
    op_disp = r.disp;
    @(negedge clk);
    op_valid = 1'b0;
    loads = int'(pc_load);
    n = 0;
    while (!op_ready && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
        loads += int'(pc_load);
    end
    if (!op_ready) begin
        timeouts++;
        $display("Timeout in %s: op_ready did not return", r.name);
    end else begin
        check_row(r, loads);
    end
endtask

// Data port model sampling on the falling edge
always @(negedge clk) begin
    mem_done = 1'b0;
    if (reset) begin
        mem_delay = 0;
    end else if (mem_req) begin
        if (mem_delay > 0) begin
            errors++;
            $display("mem_req was issued while a transfer was still waiting for mem_done");
        end
        seen_count++;
        seen_addr = mem_addr;
        seen_data = mem_wdata;
        seen_wide = mem_wide;
        seen_kind = mem_io ? (mem_write ? K_OUT : K_IO_READ) : (mem_write ? K_WRITE : K_READ);
        mem_delay = int'(lfsr_take(2)) + 1;
    end else if (mem_delay > 0) begin
        mem_delay--;
        if (mem_delay == 0) begin
            mem_done = 1'b1;
            mem_rdata = cur_rdata;
        end
    end
end

initial begin
    reset = 1'b1;
    op_valid = 1'b0;
    op_code = v33_pkg::NOP;
    op_width = v33_pkg::WORD;
    op_src0 = v33_pkg::ACC;
    op_src1 = v33_pkg::ACC;
    op_dest = v33_pkg::ACC;
    op_mod = 2'd3;
    op_rm = 3'd0;
    op_reg = 3'd0;
    op_alu = v33_pkg::ADD;
    op_cond = 4'd0;
    op_size = 4'd0;
    op_imm = '0;
    op_disp = '0;
    cur_rdata = '0;
    build_table();

    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    checks++;
    if ({op_ready, mem_req, pc_load, pc} !== {3'b100, `V33_RESET_PC}) begin
        errors++;
        $display("Error reset: expected %h, actual %h", {3'b100, `V33_RESET_PC},
                 {op_ready, mem_req, pc_load, pc});
    end

    foreach (rows[i])
        if (timeouts == 0)
            run_row(rows[i]);
    finish_run();
end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/v33_pkg.sv
verilog/v33_ifs.sv
verilog/exec_control.sv
verilog/register_file.sv
verilog/address_gen.sv
verilog/alu.sv
verilog/v33_exec.sv
tests/tb_v33_exec.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
TOP        = tb_v33_exec
FILELIST   = tb.f
BUILD_DIR  = obj_dir
PASS_TEXT  = Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
